//--- hw/fetch_pkg.sv
// Fetch stage package
// Widths, memory geometry, opcode groups and FSM states shared by the
// fetch stage, its hazard detector and the instruction memory
package fetch_pkg;

   //////////////////////////////
   // Widths and geometry
   //////////////////////////////
   localparam int word_w     = 16;
   localparam int reg_w      = 3;
   localparam int imem_depth = 256;
   // Word index bits, address bit 0 is the byte offset
   localparam int imem_aw    = $clog2(imem_depth);

   // Cycles a write notice stays pending, one per stage ahead of fetch
   localparam int raw_window = 3;

   typedef logic [word_w-1:0] word_t;
   typedef logic [reg_w-1:0]  reg_idx_t;

   // No-op encoding, used to pad programs
   localparam word_t nop_instr = 16'h0800;

   // PC after reset and PC increment
   localparam word_t rst_pc  = 16'h0000;
   localparam word_t pc_step = 16'h0002;

   //////////////////////////////
   // Opcodes
   //////////////////////////////
   typedef enum logic [4:0] {
      op_halt    = 5'b00000,
      op_nop     = 5'b00001,
      op_jump_a  = 5'b00100,
      op_jump_b  = 5'b01100,
      op_load    = 5'b10001,
      op_alu_rr  = 5'b11011,
      op_alu_ext = 5'b11100
   } opcode_e;

   // Group prefixes on the top opcode bits
   localparam logic [2:0] grp_sys     = 3'b000;
   localparam logic [2:0] grp_jump_a  = 3'b001;
   localparam logic [2:0] grp_jump_b  = 3'b011;
   // 0010x jumps carry only an immediate
   localparam logic [3:0] grp_imm_jmp = 4'b0010;
   localparam logic [3:0] grp_alu_rr  = 4'b1101;
   localparam logic [2:0] grp_alu_ext = 3'b111;

   // Fetch FSM
   typedef enum logic [1:0] {
      st_run       = 2'b00,
      st_jump_wait = 2'b01,
      st_halted    = 2'b10
   } fetch_state_e;

endpackage

//--- hw/hazard_if.sv
// Hazard interface
// Carries the decoded sources of the instruction at the PC from the
// fetch control to the RAW detector, and the RAW flag back
interface hazard_if import fetch_pkg::*; ();

   // Source register fields
   reg_idx_t src1;
   reg_idx_t src2;
   // Source actually read by this opcode
   logic     src1_used;
   logic     src2_used;
   // Combinational, same cycle
   logic     raw;

   modport ctrl (
      output src1, src2, src1_used, src2_used,
      input  raw
   );

   modport detect (
      input  src1, src2, src1_used, src2_used,
      output raw
   );

endinterface

//--- hw/instr_mem.sv
// Instruction memory
// Word array with asynchronous read, indexed by the word bits of the
// address, and a synchronous load port for program download
module instr_mem import fetch_pkg::*; (
   input  logic  clk,
   input  logic  load_en,
   input  word_t load_addr,
   input  word_t load_data,
   input  word_t addr,
   output word_t data
);

   // Program storage
   word_t mem [imem_depth];

   logic [imem_aw-1:0] rd_idx;
   logic [imem_aw-1:0] wr_idx;

   // Drop the byte offset bit
   assign rd_idx = addr[imem_aw:1];
   assign wr_idx = load_addr[imem_aw:1];

   //////////////////////////////
   // Load port
   //////////////////////////////
   // Write lands on the next edge
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[wr_idx] <= load_data;
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////
   // Combinational, follows the PC in the same cycle
   assign data = mem[rd_idx];

endmodule

//--- hw/pc_unit.sv
// Program counter
// Holds the PC, adds 2 for the sequential target and picks between a
// redirect target, the next sequential PC, or hold
module pc_unit import fetch_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  advance,
   input  logic  redirect,
   input  word_t redirect_pc,
   output word_t pc,
   output word_t pc_next
);

   word_t pc_q;
   word_t pc_d;

   //////////////////////////////
   // Increment
   //////////////////////////////
   // Sequential target, always PC + 2
   assign pc_next = pc_q + pc_step;

   //////////////////////////////
   // Next PC select
   //////////////////////////////
   always_comb begin
      // Default hold
      pc_d = pc_q;
      if (redirect) begin
         // Redirect wins over advance
         pc_d = redirect_pc;
      end else if (advance) begin
         pc_d = pc_next;
      end
   end

   // PC register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q <= rst_pc;
      end else begin
         pc_q <= pc_d;
      end
   end

   assign pc = pc_q;

endmodule

//--- hw/raw_detector.sv
// RAW hazard detector
// Keeps the last raw_window write notices from the later stages and
// flags the instruction at the PC when one of its used sources matches
// a pending destination
module raw_detector import fetch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   hazard_if.detect hz
);

   // Window entries with index 0 newest
   reg_idx_t dst_win [raw_window];
   logic     vld_win [raw_window];

   //////////////////////////////
   // Notice window
   //////////////////////////////
   // Destination fields
   always_ff @(posedge clk) begin
      dst_win[0] <= dst;
      for (int i = 1; i < raw_window; i++) begin
         dst_win[i] <= dst_win[i-1];
      end
   end

   // Valid bits clear on reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < raw_window; i++) begin
            vld_win[i] <= 1'b0;
         end
      end else begin
         vld_win[0] <= dst_valid;
         for (int i = 1; i < raw_window; i++) begin
            vld_win[i] <= vld_win[i-1];
         end
      end
   end

   //////////////////////////////
   // Compare
   //////////////////////////////
   // Only notices already sampled into the window count
   always_comb begin
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < raw_window; i++) begin
         if (vld_win[i]) begin
            // rs against entry
            if (hz.src1_used && (hz.src1 == dst_win[i])) begin
               hit = 1'b1;
            end
            // rt against entry
            if (hz.src2_used && (hz.src2 == dst_win[i])) begin
               hit = 1'b1;
            end
         end
      end
      hz.raw = hit;
   end

endmodule

//--- hw/fetch_stage.sv
// Fetch stage
// Drives the instruction memory address from the PC, decodes halt,
// jump and source fields, waits for a redirect after a jump, holds on
// RAW hazards and hands instructions to decode through a valid/ready
// output register
module fetch_stage import fetch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  word_t    instr,
   input  logic     redirect,
   input  word_t    redirect_pc,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   input  logic     out_ready,
   output word_t    imem_addr,
   output logic     out_valid,
   output word_t    out_instr,
   output word_t    out_pc_next,
   output logic     halted
);

   hazard_if hz ();

   fetch_state_e state_q;
   fetch_state_e state_d;

   word_t   pc;
   word_t   pc_next;
   opcode_e opcode;
   opcode_e out_opcode;
   logic    is_halt;
   logic    is_jump;
   logic    out_free;
   logic    fetch_go;
   logic    advance;
   logic    pc_redirect;

   // Output register
   logic    out_valid_q;
   word_t   out_instr_q;
   word_t   out_pc_next_q;
   logic    halted_q;

   //////////////////////////////
   // Decode
   //////////////////////////////
   assign opcode = opcode_e'(instr[15:11]);
   assign is_halt = (opcode == op_halt);
   // 001xx and 011xx groups transfer control
   assign is_jump = (instr[15:13] == grp_jump_a) || (instr[15:13] == grp_jump_b);

   // Source fields
   assign hz.src1 = instr[10:8];
   assign hz.src2 = instr[7:5];
   // rs read by all but the system group and the 0010x jumps
   assign hz.src1_used = (instr[15:13] != grp_sys) &&
                         (instr[15:12] != grp_imm_jmp);
   // rt only for the register ALU groups
   assign hz.src2_used = (instr[15:12] == grp_alu_rr) ||
                         (instr[15:13] == grp_alu_ext);

   raw_detector i_raw (
      .clk       (clk),
      .rst_n     (rst_n),
      .dst       (dst),
      .dst_valid (dst_valid),
      .hz        (hz.detect)
   );

   //////////////////////////////
   // Fetch control
   //////////////////////////////
   // Output slot empty or being drained this edge
   assign out_free = !out_valid_q || out_ready;
   assign fetch_go = (state_q == st_run) && !hz.raw && out_free;

   // Jumps and halt keep the PC where it is
   assign advance = fetch_go && !is_jump && !is_halt;
   // Halted PC is frozen
   assign pc_redirect = redirect && (state_q != st_halted);

   pc_unit i_pc (
      .clk         (clk),
      .rst_n       (rst_n),
      .advance     (advance),
      .redirect    (pc_redirect),
      .redirect_pc (redirect_pc),
      .pc          (pc),
      .pc_next     (pc_next)
   );

   assign imem_addr = pc;

   // FSM next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_run: begin
            if (fetch_go && is_halt) begin
               state_d = st_halted;
            end else if (fetch_go && is_jump) begin
               state_d = st_jump_wait;
            end
         end
         st_jump_wait: begin
            // Wait length set by the later stages
            if (redirect) begin
               state_d = st_run;
            end
         end
         st_halted: begin
            // Only reset leaves
            state_d = st_halted;
         end
         default: begin
            state_d = st_run;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= st_run;
      end else begin
         state_q <= state_d;
      end
   end

   //////////////////////////////
   // Output register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid_q <= 1'b0;
      end else if (fetch_go) begin
         out_valid_q <= 1'b1;
      end else if (out_ready) begin
         // Drained with nothing behind it
         out_valid_q <= 1'b0;
      end
   end

   // Payload held while the slot is full and stalled
   always_ff @(posedge clk) begin
      if (fetch_go) begin
         out_instr_q   <= instr;
         out_pc_next_q <= pc_next;
      end
   end

   // Halt flag rises on the edge that transfers the halt
   assign out_opcode = opcode_e'(out_instr_q[15:11]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted_q <= 1'b0;
      end else if (out_valid_q && out_ready && (out_opcode == op_halt)) begin
         halted_q <= 1'b1;
      end
   end

   assign out_valid   = out_valid_q;
   assign out_instr   = out_instr_q;
   assign out_pc_next = out_pc_next_q;
   assign halted      = halted_q;

endmodule

//--- hw/fetch_top.sv
// Fetch top level
// Joins the fetch stage to the instruction memory, exposes the
// redirect, write notice, program load and decode handshake ports
module fetch_top import fetch_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     redirect,
   input  word_t    redirect_pc,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   input  logic     load_en,
   input  word_t    load_addr,
   input  word_t    load_data,
   input  logic     out_ready,
   output logic     out_valid,
   output word_t    out_instr,
   output word_t    out_pc_next,
   output logic     halted
);

   // Memory read path
   word_t imem_addr;
   word_t imem_data;

   //////////////////////////////
   // Instruction memory
   //////////////////////////////
   instr_mem i_imem (
      .clk       (clk),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .addr      (imem_addr),
      .data      (imem_data)
   );

   //////////////////////////////
   // Fetch stage
   //////////////////////////////
   fetch_stage i_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (imem_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .dst         (dst),
      .dst_valid   (dst_valid),
      .out_ready   (out_ready),
      .imem_addr   (imem_addr),
      .out_valid   (out_valid),
      .out_instr   (out_instr),
      .out_pc_next (out_pc_next),
      .halted      (halted)
   );

endmodule

//--- bench/fetch_tb_assert.sv
// Fetch top assertions
// Output stability under back-pressure, empty output after reset and
// a sticky halt flag, bound onto the fetch top level
module fetch_tb_assert import fetch_pkg::*; (
   input logic  clk,
   input logic  rst_n,
   input logic  out_valid,
   input logic  out_ready,
   input word_t out_instr,
   input word_t out_pc_next,
   input logic  halted
);

   // Failed property count
   int unsigned fail_count = 0;

   // Slot held while decode stalls
   stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_instr) && $stable(out_pc_next))
      else begin
         $error("output register changed under back-pressure");
         fail_count++;
      end

   // Nothing valid right after reset
   rst_empty: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else begin
         $error("out_valid high in the cycle after reset");
         fail_count++;
      end

   // Only reset clears halted
   halt_sticky: assert property (@(posedge clk) rst_n && halted |=> halted)
      else begin
         $error("halted fell without reset");
         fail_count++;
      end

endmodule

bind fetch_top fetch_tb_assert i_assert (.*);

//--- bench/fetch_tb.sv
// Fetch stage testbench
// Loads a program during reset, runs a stimulus table against a cycle
// model of the fetch rules and checks every output and transfer
module fetch_tb import fetch_pkg::*; ();

   typedef struct packed {
      logic [1:0] ready_mode;  // 0 low, 1 high, 2 random
      logic       redirect;
      word_t      redirect_pc;
      reg_idx_t   dst;
      logic       dst_valid;
      logic [7:0] cycles;
   } stim_row_t;

   logic     clk;
   logic     rst_n;
   logic     redirect;
   word_t    redirect_pc;
   reg_idx_t dst;
   logic     dst_valid;
   logic     load_en;
   word_t    load_addr;
   word_t    load_data;
   logic     out_ready;
   logic     out_valid;
   word_t    out_instr;
   word_t    out_pc_next;
   logic     halted;

   // Program as {address, instruction}
   logic [31:0] prog [13];
   stim_row_t   stim [12];
   word_t       exp_addr [11];
   word_t       model_mem [imem_depth];
   word_t       got_addr [$];
   logic [31:0] rnd;

   // Reference model state
   word_t        m_pc;
   fetch_state_e m_state;
   logic         m_ov;
   word_t        m_instr;
   word_t        m_pcn;
   logic         m_halted;
   reg_idx_t     win_dst [raw_window];
   logic         win_vld [raw_window];

   fetch_top i_dut (.*);

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check(input string name, input logic [15:0] actual,
                        input logic [15:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("Fail at %0t: %s is %h, expected %h",
                             $time, name, actual, expected));
      end
   endtask

   ////////////////////////////////
   // Reference model
   ////////////////////////////////
   // rs read unless 000xx or 0010x and rt read for 1101x and 111xx
   function automatic logic source_pending(input word_t ins);
      logic rs_read;
      logic rt_read;
      logic hit;
      int   i;
      rs_read = (ins[15:13] != 3'b000) && (ins[15:12] != 4'b0010);
      rt_read = (ins[15:12] == 4'b1101) || (ins[15:13] == 3'b111);
      hit = 1'b0;
      for (i = 0; i < raw_window; i++) begin
         if (win_vld[i] && rs_read && (win_dst[i] == ins[10:8])) hit = 1'b1;
         if (win_vld[i] && rt_read && (win_dst[i] == ins[7:5])) hit = 1'b1;
      end
      return hit;
   endfunction

   // One clock edge of the fetch rules
   task automatic model_step(input logic rdy, input logic redir, input word_t rpc,
                             input reg_idx_t d, input logic dv);
      word_t ins;
      logic  halt_op;
      logic  jump_op;
      logic  take;
      int    i;
      ins     = model_mem[m_pc[8:1]];
      halt_op = (ins[15:11] == 5'b00000);
      jump_op = (ins[15:13] == 3'b001) || (ins[15:13] == 3'b011);
      take    = (m_state == st_run) && !source_pending(ins) && (!m_ov || rdy);
      // Halt leaving the output register
      if (m_ov && rdy && (m_instr[15:11] == 5'b00000)) m_halted = 1'b1;
      if (take) begin
         m_ov    = 1'b1;
         m_instr = ins;
         m_pcn   = m_pc + 16'd2;
      end else if (rdy) begin
         m_ov = 1'b0;
      end
      if (redir && (m_state != st_halted)) m_pc = rpc;
      else if (take && !jump_op && !halt_op) m_pc = m_pc + 16'd2;
      if (take && halt_op) m_state = st_halted;
      else if (take && jump_op) m_state = st_jump_wait;
      else if ((m_state == st_jump_wait) && redir) m_state = st_run;
      for (i = raw_window - 1; i > 0; i--) begin
         win_dst[i] = win_dst[i-1];
         win_vld[i] = win_vld[i-1];
      end
      win_dst[0] = d;
      win_vld[0] = dv;
   endtask

   task automatic compare_outputs();
      if (i_dut.i_assert.fail_count != 0) begin
         abort_run("A bound assertion on the fetch top failed");
      end
      check("out_valid", out_valid, m_ov);
      check("halted", halted, m_halted);
      if (m_ov) begin
         check("out_instr", out_instr, m_instr);
         check("out_pc_next", out_pc_next, m_pcn);
      end
   endtask

   // Called on a falling edge and returns on the next one
   task automatic run_cycle(input logic rdy, input logic redir, input word_t rpc,
                            input reg_idx_t d, input logic dv);
      compare_outputs();
      out_ready   = rdy;
      redirect    = redir;
      redirect_pc = rpc;
      dst         = d;
      dst_valid   = dv;
      // Transfer on the coming edge
      if (out_valid && rdy) got_addr.push_back(out_pc_next - 16'd2);
      model_step(rdy, redir, rpc, d, dv);
      @(negedge clk);
   endtask

   ////////////////////////////////
   // Stimulus
   ////////////////////////////////
   initial begin
      int   timeout;
      logic rdy;
      clk = 1'b0;
      rst_n = 1'b0;
      redirect = 1'b0;
      redirect_pc = '0;
      dst = '0;
      dst_valid = 1'b0;
      load_en = 1'b0;
      load_addr = '0;
      load_data = '0;
      out_ready = 1'b0;
      rnd = 32'h735b;
      // alu r1 r2, load r3, alu r4 r5, jump, then 0x20 and 0x40 blocks
      prog = '{32'h0000_D940, 32'h0002_8B00, 32'h0004_DCA0, 32'h0006_2000,
               32'h0008_0800, 32'h0020_DEE0, 32'h0022_8A00, 32'h0024_6100,
               32'h0040_0800, 32'h0042_DD00, 32'h0044_8D00, 32'h0046_0000,
               32'h0048_D940};
      stim = '{'{2'd1, 1'b0, 16'h0000, 3'd3, 1'b1, 8'd1},
               '{2'd1, 1'b0, 16'h0000, 3'd0, 1'b0, 8'd6},
               '{2'd2, 1'b0, 16'h0000, 3'd0, 1'b0, 8'd5},
               '{2'd1, 1'b1, 16'h0020, 3'd0, 1'b0, 8'd1},
               '{2'd2, 1'b0, 16'h0000, 3'd5, 1'b1, 8'd3},
               '{2'd1, 1'b0, 16'h0000, 3'd1, 1'b1, 8'd1},
               '{2'd1, 1'b0, 16'h0000, 3'd0, 1'b0, 8'd6},
               '{2'd1, 1'b1, 16'h0040, 3'd0, 1'b0, 8'd1},
               '{2'd2, 1'b0, 16'h0000, 3'd0, 1'b1, 8'd2},
               '{2'd1, 1'b0, 16'h0000, 3'd0, 1'b0, 8'd10},
               '{2'd2, 1'b1, 16'h0020, 3'd0, 1'b0, 8'd1},
               '{2'd1, 1'b0, 16'h0000, 3'd0, 1'b0, 8'd4}};
      exp_addr = '{16'h00, 16'h02, 16'h04, 16'h06, 16'h20, 16'h22,
                   16'h24, 16'h40, 16'h42, 16'h44, 16'h46};
      // Program download while in reset
      @(negedge clk);
      foreach (prog[i]) begin
         load_en   = 1'b1;
         load_addr = prog[i][31:16];
         load_data = prog[i][15:0];
         // Word index is address bits 8:1
         model_mem[prog[i][24:17]] = prog[i][15:0];
         @(negedge clk);
      end
      load_en = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      m_pc = '0;
      m_state = st_run;
      m_ov = 1'b0;
      m_instr = '0;
      m_pcn = '0;
      m_halted = 1'b0;
      foreach (win_vld[i]) win_vld[i] = 1'b0;
      foreach (stim[r]) begin
         for (int c = 0; c < stim[r].cycles; c++) begin
            rdy = (stim[r].ready_mode == 2'd2) ? rnd[7] : stim[r].ready_mode[0];
            rnd = xorshift(rnd);
            run_cycle(rdy, stim[r].redirect, stim[r].redirect_pc,
                      stim[r].dst, stim[r].dst_valid);
         end
      end
      // Halt should be out by now
      timeout = 0;
      while (!halted) begin
         if (timeout >= 20) begin
            abort_run("Timeout waiting for halted to rise");
         end else begin
            run_cycle(1'b1, 1'b0, '0, '0, 1'b0);
            timeout++;
         end
      end
      compare_outputs();
      check("transfer count", got_addr.size(), $size(exp_addr));
      foreach (exp_addr[i]) check("transfer address", got_addr[i], exp_addr[i]);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- files.f
hw/fetch_pkg.sv
hw/hazard_if.sv
hw/instr_mem.sv
hw/pc_unit.sv
hw/raw_detector.sv
hw/fetch_stage.sv
hw/fetch_top.sv
bench/fetch_tb_assert.sv
bench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_stage

sources:
  - hw/fetch_pkg.sv
  - hw/hazard_if.sv
  - hw/instr_mem.sv
  - hw/pc_unit.sv
  - hw/raw_detector.sv
  - hw/fetch_stage.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - bench/fetch_tb_assert.sv
      - bench/fetch_tb.sv
